// ==== hw/alu_stage.sv ====
`include "backend_defines.svh"

module alu_stage import backend_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  exec_t   exec_i,
  // Result in the execute cycle, for forwarding
  output result_t ex_o,
  // Same result one cycle later, for the bank write
  output result_t wb_o
);

  xlen_t result;
  logic  wb_valid_q;
  preg_t wb_dest_q;
  xlen_t wb_data_q;

  // Single-cycle ALU, every opcode finishes in execute
  always_comb begin
    case (exec_i.op)
      `BE_OP_ADD: result = exec_i.a + exec_i.b;
      `BE_OP_SUB: result = exec_i.a - exec_i.b;
      `BE_OP_AND: result = exec_i.a & exec_i.b;
      `BE_OP_OR:  result = exec_i.a | exec_i.b;
      `BE_OP_XOR: result = exec_i.a ^ exec_i.b;
      // Shift amount is the low five bits of b
      `BE_OP_SLL: result = exec_i.a << exec_i.b[4:0];
      `BE_OP_SRL: result = exec_i.a >> exec_i.b[4:0];
      `BE_OP_SLT: result = xlen_t'($signed(exec_i.a) < $signed(exec_i.b));
      default:    result = '0;
    endcase
  end

  assign ex_o = '{valid: exec_i.valid, dest: exec_i.dest, data: result};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= ex_o.valid;
    end
  end

  // Destination and data are only meaningful while valid is set
  always_ff @(posedge clk_i) begin
    wb_dest_q <= ex_o.dest;
    wb_data_q <= ex_o.data;
  end

  assign wb_o = '{valid: wb_valid_q, dest: wb_dest_q, data: wb_data_q};

endmodule

// ==== hw/backend_defines.svh ====
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// Physical register file geometry
`define BE_NREGS 64
`define BE_XLEN 32

// The init sequencer clears one index per cycle in all three banks
`define BE_INIT_CYCLES `BE_NREGS

// ALU opcodes, shifts take the low 5 bits of operand b
`define BE_OP_ADD 3'd0
`define BE_OP_SUB 3'd1
`define BE_OP_AND 3'd2
`define BE_OP_OR 3'd3
`define BE_OP_XOR 3'd4
`define BE_OP_SLL 3'd5
`define BE_OP_SRL 3'd6
// Signed compare, result is 0 or 1
`define BE_OP_SLT 3'd7

`endif

// ==== hw/backend_pkg.sv ====
`include "backend_defines.svh"

package backend_pkg;

  // Data word and physical register index
  typedef logic [`BE_XLEN-1:0] xlen_t;
  typedef logic [$clog2(`BE_NREGS)-1:0] preg_t;
  typedef logic [2:0] alu_op_t;

  // An op as handed over by the issuer, one per lane
  typedef struct packed {
    logic    valid;
    alu_op_t op;
    preg_t   src_a;
    preg_t   src_b;
    preg_t   dest;
  } issue_t;

  // An op in execute, with its operands already resolved
  typedef struct packed {
    logic    valid;
    alu_op_t op;
    preg_t   dest;
    xlen_t   a;
    xlen_t   b;
  } exec_t;

  // A result on the execute bus, the writeback bus or the load fill port
  typedef struct packed {
    logic  valid;
    preg_t dest;
    xlen_t data;
  } result_t;

  // Bank clearing runs first, then the file serves normal traffic
  typedef enum logic {
    RF_CLEAR,
    RF_READY
  } rf_state_e;

endpackage

// ==== hw/int_backend.sv ====
module int_backend import backend_pkg::*; (
  input  logic          clk_i,
  input  logic          arst_n_i,
  // Dual issue, lane 0 older than lane 1
  input  issue_t        issue0_i,
  input  issue_t        issue1_i,
  // Fill write from the load unit
  input  result_t       load_i,
  // Side read ports
  input  preg_t  [1:0]  side_src_i,
  output xlen_t  [1:0]  side_data_o,
  // Writeback buses, valid two cycles after issue
  output result_t       wb0_o,
  output result_t       wb1_o,
  output logic          init_busy_o
);

  preg_t   [3:0] rd_src;
  xlen_t   [3:0] rd_data;
  exec_t         exec0;
  exec_t         exec1;
  result_t       ex0;
  result_t       ex1;

  // Register read stage, operands resolved in the issue cycle
  issue_stage u_issue (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .issue0_i    (issue0_i),
    .issue1_i    (issue1_i),
    .init_busy_i (init_busy_o),
    .rd_src_o    (rd_src),
    .rd_data_i   (rd_data),
    .exec0_o     (exec0),
    .exec1_o     (exec1)
  );

  // Lane 0 writes bank 0
  alu_stage u_alu0 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .exec_i   (exec0),
    .ex_o     (ex0),
    .wb_o     (wb0_o)
  );

  // Lane 1 writes bank 1
  alu_stage u_alu1 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .exec_i   (exec1),
    .ex_o     (ex1),
    .wb_o     (wb1_o)
  );

  // The load port goes straight into bank 2
  xor_regfile u_rf (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .rd_src_i    (rd_src),
    .rd_data_o   (rd_data),
    .side_src_i  (side_src_i),
    .side_data_o (side_data_o),
    .ex0_i       (ex0),
    .ex1_i       (ex1),
    .wb0_i       (wb0_o),
    .wb1_i       (wb1_o),
    .load_i      (load_i),
    .init_busy_o (init_busy_o)
  );

endmodule

// ==== hw/issue_stage.sv ====
module issue_stage import backend_pkg::*; (
  input  logic          clk_i,
  input  logic          arst_n_i,
  // Lane 0 is the older op of the pair
  input  issue_t        issue0_i,
  input  issue_t        issue1_i,
  input  logic          init_busy_i,
  // Sources go out in the issue cycle and forwarded data comes back the same cycle
  output preg_t  [3:0]  rd_src_o,
  input  xlen_t  [3:0]  rd_data_i,
  output exec_t         exec0_o,
  output exec_t         exec1_o
);

  issue_t lane_iss  [2];
  exec_t  lane_exec [2];

  assign lane_iss[0] = issue0_i;
  assign lane_iss[1] = issue1_i;

  for (genvar l = 0; l < 2; l++) begin : g_lane
    logic    valid_q;
    alu_op_t op_q;
    preg_t   dest_q;
    xlen_t   a_q;
    xlen_t   b_q;

    // Read ports 2l and 2l+1 belong to this lane
    assign rd_src_o[2*l]   = lane_iss[l].src_a;
    assign rd_src_o[2*l+1] = lane_iss[l].src_b;

    // Ops offered while the banks are still being cleared are dropped
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= lane_iss[l].valid && !init_busy_i;
      end
    end

    // Payload follows only real issues so execute sees stable operands when idle
    always_ff @(posedge clk_i) begin
      if (lane_iss[l].valid) begin
        op_q   <= lane_iss[l].op;
        dest_q <= lane_iss[l].dest;
        a_q    <= rd_data_i[2*l];
        b_q    <= rd_data_i[2*l+1];
      end
    end

    assign lane_exec[l] = '{valid: valid_q, op: op_q, dest: dest_q, a: a_q, b: b_q};
  end

  assign exec0_o = lane_exec[0];
  assign exec1_o = lane_exec[1];

  // Both lanes reach writeback together and would collide in the register file
  a_distinct_dest: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (issue0_i.valid && issue1_i.valid && !init_busy_i) |->
      (issue0_i.dest != issue1_i.dest));

endmodule

// ==== hw/xor_regfile.sv ====
`include "backend_defines.svh"

module xor_regfile import backend_pkg::*; (
  input  logic           clk_i,
  input  logic           arst_n_i,
  // Operand read ports, two per lane
  input  preg_t   [3:0]  rd_src_i,
  output xlen_t   [3:0]  rd_data_o,
  // Side read ports for outside logic such as a store unit
  input  preg_t   [1:0]  side_src_i,
  output xlen_t   [1:0]  side_data_o,
  // Execute buses, used for forwarding only
  input  result_t        ex0_i,
  input  result_t        ex1_i,
  // Writeback buses, forwarded and written to banks 0 and 1
  input  result_t        wb0_i,
  input  result_t        wb1_i,
  // Load fill writes bank 2 and is never forwarded
  input  result_t        load_i,
  output logic           init_busy_o
);

  // One bank per write port, the stored value is the XOR of all three
  xlen_t bank0 [`BE_NREGS];
  xlen_t bank1 [`BE_NREGS];
  xlen_t bank2 [`BE_NREGS];

  rf_state_e state_q;
  preg_t     init_idx_q;
  logic      ready;
  logic      load_we;

  assign ready       = (state_q == RF_READY);
  assign init_busy_o = !ready;

  // Loads that arrive while the banks are being cleared are dropped
  assign load_we = load_i.valid && ready;

  // Init sequencer walks every index once after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= RF_CLEAR;
      init_idx_q <= '0;
    end else if (state_q == RF_CLEAR) begin
      init_idx_q <= init_idx_q + 1'b1;
      if (init_idx_q == preg_t'(`BE_INIT_CYCLES - 1)) begin
        state_q <= RF_READY;
      end
    end
  end

  // Each port writes its own bank so that the XOR of all three equals the new data
  always_ff @(posedge clk_i) begin
    if (!ready) begin
      // Zeros in all banks make the XOR read defined from the start
      bank0[init_idx_q] <= '0;
      bank1[init_idx_q] <= '0;
      bank2[init_idx_q] <= '0;
    end else begin
      if (wb0_i.valid) begin
        bank0[wb0_i.dest] <= wb0_i.data ^ bank1[wb0_i.dest] ^ bank2[wb0_i.dest];
      end
      if (wb1_i.valid) begin
        bank1[wb1_i.dest] <= wb1_i.data ^ bank0[wb1_i.dest] ^ bank2[wb1_i.dest];
      end
      if (load_we) begin
        bank2[load_i.dest] <= load_i.data ^ bank0[load_i.dest] ^ bank1[load_i.dest];
      end
    end
  end

  // Operand ports see wb lane 0, wb lane 1, ex lane 0, ex lane 1, then the banks
  for (genvar p = 0; p < 4; p++) begin : g_rd
    xlen_t bank_val;

    assign bank_val = bank0[rd_src_i[p]] ^ bank1[rd_src_i[p]] ^ bank2[rd_src_i[p]];

    always_comb begin
      if (wb0_i.valid && (wb0_i.dest == rd_src_i[p])) begin
        rd_data_o[p] = wb0_i.data;
      end else if (wb1_i.valid && (wb1_i.dest == rd_src_i[p])) begin
        rd_data_o[p] = wb1_i.data;
      end else if (ex0_i.valid && (ex0_i.dest == rd_src_i[p])) begin
        rd_data_o[p] = ex0_i.data;
      end else if (ex1_i.valid && (ex1_i.dest == rd_src_i[p])) begin
        rd_data_o[p] = ex1_i.data;
      end else begin
        rd_data_o[p] = bank_val;
      end
    end
  end

  // Side ports only bypass the writeback buses
  for (genvar s = 0; s < 2; s++) begin : g_side
    xlen_t bank_val;

    assign bank_val = bank0[side_src_i[s]] ^ bank1[side_src_i[s]] ^ bank2[side_src_i[s]];

    always_comb begin
      if (wb0_i.valid && (wb0_i.dest == side_src_i[s])) begin
        side_data_o[s] = wb0_i.data;
      end else if (wb1_i.valid && (wb1_i.dest == side_src_i[s])) begin
        side_data_o[s] = wb1_i.data;
      end else begin
        side_data_o[s] = bank_val;
      end
    end
  end

  // Two ports hitting one index would leave the XOR sum holding neither value
  a_no_write_clash: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !((wb0_i.valid && wb1_i.valid && (wb0_i.dest == wb1_i.dest)) ||
      (wb0_i.valid && load_we && (wb0_i.dest == load_i.dest)) ||
      (wb1_i.valid && load_we && (wb1_i.dest == load_i.dest))));

  // The issue stage gates ops during init, so no ALU result may reach writeback then
  a_no_wb_during_init: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !ready |-> !(wb0_i.valid || wb1_i.valid));

endmodule

// ==== int_backend.f ====
+incdir+hw
hw/backend_pkg.sv
hw/xor_regfile.sv
hw/issue_stage.sv
hw/alu_stage.sv
hw/int_backend.sv
sim/int_backend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f int_backend.f --top-module int_backend_tb \
  -o int_backend_sim \
  && ./obj_dir/int_backend_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== sim/int_backend_tb.sv ====
`include "backend_defines.svh"

module int_backend_tb import backend_pkg::*; ();

  localparam int PERIOD = 8;
  localparam int RESET_CYCLES = 10;
  localparam int N_RANDOM = 200;
  localparam int N_CHAIN = 24;
  // Init, side sweep, load sweep, random ops, chains, gap tests and drain
  localparam int TOTAL_CYCLES = RESET_CYCLES + `BE_INIT_CYCLES + `BE_NREGS / 2
                                + `BE_NREGS + 1 + N_RANDOM + N_CHAIN + 28 + 4;

  // One expected pair of writeback packets and the cycle they must show up in
  typedef struct packed {
    int unsigned due;
    result_t     wb0;
    result_t     wb1;
  } expect_t;

  logic         clk;
  logic         arst_n;
  issue_t       issue0;
  issue_t       issue1;
  result_t      load;
  preg_t  [1:0] side_src;
  xlen_t  [1:0] side_data;
  result_t      wb0;
  result_t      wb1;
  logic         init_busy;

  xlen_t       model [`BE_NREGS];
  expect_t     exp_q [$];
  int unsigned cyc = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  integer      seed;

  int_backend DUT (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .issue0_i    (issue0),
    .issue1_i    (issue1),
    .load_i      (load),
    .side_src_i  (side_src),
    .side_data_o (side_data),
    .wb0_o       (wb0),
    .wb1_o       (wb1),
    .init_busy_o (init_busy)
  );

  always #(PERIOD / 2) clk = ~clk;

  // Cycle number that the driver and the compare process both read
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ALU behaviour as the opcode table defines it
  function automatic xlen_t alu_ref(input alu_op_t op, input xlen_t a, input xlen_t b);
    xlen_t r;
    case (op)
      `BE_OP_ADD: r = a + b;
      `BE_OP_SUB: r = a - b;
      `BE_OP_AND: r = a & b;
      `BE_OP_OR:  r = a | b;
      `BE_OP_XOR: r = a ^ b;
      `BE_OP_SLL: r = a << b[4:0];
      `BE_OP_SRL: r = a >> b[4:0];
      `BE_OP_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:    r = '0;
    endcase
    return r;
  endfunction

  task automatic value_error(input string msg);
    value_errors++;
    $display("** Error at time %0t: %s", $time, msg);
  endtask

  task automatic check_wb(input int lane, input result_t got, input result_t want);
    if (got.valid !== want.valid) begin
      value_error($sformatf("wb%0d valid is %b, expected %b", lane, got.valid, want.valid));
    end else if (want.valid && (got.dest !== want.dest || got.data !== want.data)) begin
      value_error($sformatf("wb%0d carries p%0d=%h, expected p%0d=%h",
                            lane, got.dest, got.data, want.dest, want.data));
    end
  endtask

  // One clock cycle of stimulus, model update and optional side port check
  task automatic drive_cycle(input issue_t i0, input issue_t i1, input result_t ld,
                             input preg_t s0, input preg_t s1, input logic side_chk);
    xlen_t exp_s0;
    xlen_t exp_s1;
    xlen_t r0;
    xlen_t r1;
    @(posedge clk);
    #1;
    issue0 = i0;
    issue1 = i1;
    load = ld;
    side_src = {s1, s0};
    // Side ports see writes up to the wb bus and callers avoid registers still in execute
    exp_s0 = model[s0];
    exp_s1 = model[s1];
    // Both lanes read their operands before either result exists
    r0 = alu_ref(i0.op, model[i0.src_a], model[i0.src_b]);
    r1 = alu_ref(i1.op, model[i1.src_a], model[i1.src_b]);
    if (i0.valid) begin
      model[i0.dest] = r0;
    end
    if (i1.valid) begin
      model[i1.dest] = r1;
    end
    if (ld.valid) begin
      model[ld.dest] = ld.data;
    end
    if (i0.valid || i1.valid) begin
      exp_q.push_back('{due: cyc + 2,
                        wb0: '{valid: i0.valid, dest: i0.dest, data: r0},
                        wb1: '{valid: i1.valid, dest: i1.dest, data: r1}});
    end
    @(negedge clk);
    if (side_chk && side_data[0] !== exp_s0) begin
      value_error($sformatf("side 0 read p%0d=%h, expected %h", s0, side_data[0], exp_s0));
    end
    if (side_chk && side_data[1] !== exp_s1) begin
      value_error($sformatf("side 1 read p%0d=%h, expected %h", s1, side_data[1], exp_s1));
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      drive_cycle('0, '0, '0, '0, '0, 1'b0);
    end
  endtask

  task automatic finish_run();
    $display("Run complete: %0d value errors, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // Writeback must carry exactly the queued packet two cycles after issue and nothing else
  always @(negedge clk) begin : compare_wb
    expect_t e;
    e = '0;
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
    end
    if (arst_n) begin
      check_wb(0, wb0, e.wb0);
      check_wb(1, wb1, e.wb1);
    end
  end

  initial begin : watchdog
    #(PERIOD * (TOTAL_CYCLES + 50));
    other_errors++;
    $display("Watchdog expired in cycle %0d, the test sequence never completed", cyc);
    finish_run();
  end

  initial begin : stimulus
    int          n;
    logic [31:0] rnd;
    preg_t       d0;
    preg_t       d1;
    preg_t       p0;
    preg_t       p1;
    issue_t      prod;
    issue_t      cons;
    seed = 32'h05f1_1b93;
    clk = 1'b0;
    arst_n = 1'b0;
    issue0 = '0;
    issue1 = '0;
    load = '0;
    side_src = '0;
    for (int r = 0; r < `BE_NREGS; r++) begin
      model[r] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    // An op and a load held for the whole init phase must both vanish
    issue0 = issue_t'{1'b1, `BE_OP_ADD, 6'd0, 6'd0, 6'd5};
    load = '{valid: 1'b1, dest: 6'd9, data: 32'hdead_beef};
    n = 0;
    while (init_busy === 1'b1 && n < 4 * `BE_INIT_CYCLES) begin
      @(posedge clk);
      #1;
      n++;
    end
    issue0 = '0;
    load = '0;
    if (init_busy !== 1'b0) begin
      other_errors++;
      $display("Init sequencer still busy after %0d cycles", n);
    end else if (n != `BE_INIT_CYCLES) begin
      other_errors++;
      $display("Init sequencer took %0d cycles instead of %0d", n, `BE_INIT_CYCLES);
    end

    // Every register reads zero once the banks are cleared
    for (int r = 0; r < `BE_NREGS; r += 2) begin
      drive_cycle('0, '0, '0, preg_t'(r), preg_t'(r + 1), 1'b1);
    end

    // Fill all registers while checking that last cycle's load is visible and this one is not
    for (int r = 0; r < `BE_NREGS; r++) begin
      rnd = $random(seed);
      drive_cycle('0, '0, '{valid: 1'b1, dest: preg_t'(r), data: rnd},
                  preg_t'(r - 1), preg_t'(r), 1'b1);
    end
    drive_cycle('0, '0, '0, preg_t'(`BE_NREGS - 1), preg_t'(`BE_NREGS - 2), 1'b1);

    // Destinations rotate so none repeats within 32 cycles while sources stay random
    for (int k = 0; k < N_RANDOM; k++) begin
      d0 = preg_t'(2 * k);
      d1 = preg_t'(2 * k + 1);
      rnd = $random(seed);
      drive_cycle(issue_t'{rnd[0] | rnd[1], rnd[4:2], rnd[10:5], rnd[16:11], d0},
                  issue_t'{rnd[17] | rnd[18], rnd[21:19], rnd[27:22], rnd[31:26], d1},
                  '0, '0, '0, 1'b0);
    end

    // Each lane consumes both results of the previous cycle over the execute forward
    p0 = 6'd0;
    p1 = 6'd1;
    for (int k = 0; k < N_CHAIN; k++) begin
      rnd = $random(seed);
      d0 = preg_t'(16 + k % 8);
      d1 = preg_t'(32 + k % 8);
      drive_cycle(issue_t'{1'b1, rnd[0] ? `BE_OP_ADD : `BE_OP_SUB, p0, p1, d0},
                  issue_t'{1'b1, rnd[1] ? `BE_OP_XOR : `BE_OP_ADD, p1, p0, d1},
                  '0, '0, '0, 1'b0);
      p0 = d0;
      p1 = d1;
    end

    // Distance 2 hits the writeback forward and distance 3 the banks with side reads alongside
    for (int gap = 2; gap <= 3; gap++) begin
      for (int rep = 0; rep < 4; rep++) begin
        rnd = $random(seed);
        d0 = preg_t'(48 + rep);
        d1 = preg_t'(56 + rep);
        prod = issue_t'{1'b1, rnd[2:0], rnd[8:3], rnd[14:9], d0};
        cons = issue_t'{1'b1, rnd[17:15], d0, rnd[23:18], d1};
        if (rep % 2 == 0) begin
          drive_cycle(prod, '0, '0, '0, '0, 1'b0);
          idle_cycles(gap - 1);
          drive_cycle('0, cons, '0, d0, d1, 1'b1);
        end else begin
          drive_cycle('0, prod, '0, '0, '0, 1'b0);
          idle_cycles(gap - 1);
          drive_cycle(cons, '0, '0, d0, d1, 1'b1);
        end
      end
    end

    idle_cycles(4);
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d expected writeback packets never appeared", exp_q.size());
    end
    finish_run();
  end

endmodule
